/* logic/tcdm_pkg.sv */
// shared sizes and request types of the TCDM subsystem
package tcdm_pkg;

  // four masters share four banks, one arbiter per bank
  localparam int unsigned NUM_MASTERS = 4;
  localparam int unsigned NUM_BANKS = 4;

  // each bank holds 256 words of 32 bits
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned DATA_W = 32;

  // one byte enable per byte lane of the data word
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BE_W = DATA_W / BYTE_W;

  // the word address splits into bank select and bank-local index
  localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS);
  localparam int unsigned ADDR_W = BANK_SEL_W + BANK_ADDR_W;

  // the map is word interleaved, so the lowest bits pick the bank
  // and the bits above them index the word inside that bank
  localparam int unsigned BANK_SEL_LSB = 0;
  localparam int unsigned BANK_ADDR_LSB = BANK_SEL_W;

  // width of a master index, used by the round-robin pointer
  localparam int unsigned MASTER_IDX_W = $clog2(NUM_MASTERS);

  // request as issued by a master, with the global word address
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } tcdm_req_t;

  // request as seen by a bank, the bank select bits already stripped
  typedef struct packed {
    logic                   we;
    logic [BANK_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
    logic [BE_W-1:0]        be;
  } bank_req_t;

endpackage

/* logic/tcdm_bank.sv */
`timescale 1ns/10ps

// behavioral single-port SRAM bank
// writes are byte masked and reads come back one cycle after the request
module tcdm_bank (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [tcdm_pkg::BANK_ADDR_W-1:0]  addr_i,
  input  logic [tcdm_pkg::DATA_W-1:0]       wdata_i,
  input  logic [tcdm_pkg::BE_W-1:0]         be_i,
  output logic [tcdm_pkg::DATA_W-1:0]       rdata_o
);

  // storage array, contents are undefined until written
  logic [tcdm_pkg::DATA_W-1:0] mem_q [tcdm_pkg::BANK_WORDS];

  // byte lanes that are written in this cycle
  logic [tcdm_pkg::BE_W-1:0] wr_lane;

  // a lane is written only for an accepted write with its enable set
  assign wr_lane = {tcdm_pkg::BE_W{req_i & we_i}} & be_i;

  // write port, each enabled lane is updated at this clock edge
  // lanes whose enable is low keep their old contents
  always_ff @(posedge clk_i) begin
    for (int unsigned lane = 0; lane < tcdm_pkg::BE_W; lane++) begin
      if (wr_lane[lane]) begin
        mem_q[addr_i][lane*tcdm_pkg::BYTE_W +: tcdm_pkg::BYTE_W] <=
          wdata_i[lane*tcdm_pkg::BYTE_W +: tcdm_pkg::BYTE_W];
      end
    end
  end

  // read port, the addressed word is registered on every request
  // on a write this returns the word as it was before the write
  // between requests the output keeps the last value read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* logic/tcdm_bank_arbiter.sv */
`timescale 1ns/10ps

// round-robin arbiter in front of one bank
// the grant is combinational in the request cycle, rvalid follows one cycle later
module tcdm_bank_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]    valid_i,
  input  tcdm_pkg::bank_req_t                 req_i [tcdm_pkg::NUM_MASTERS],
  output logic [tcdm_pkg::NUM_MASTERS-1:0]    gnt_o,
  output logic [tcdm_pkg::NUM_MASTERS-1:0]    rvalid_o,
  output logic                                bank_req_o,
  output logic                                bank_we_o,
  output logic [tcdm_pkg::BANK_ADDR_W-1:0]    bank_addr_o,
  output logic [tcdm_pkg::DATA_W-1:0]         bank_wdata_o,
  output logic [tcdm_pkg::BE_W-1:0]           bank_be_o
);

  // master with the highest priority in this cycle
  logic [tcdm_pkg::MASTER_IDX_W-1:0] rr_ptr_q;

  // master that wins the bank in this cycle
  logic [tcdm_pkg::MASTER_IDX_W-1:0] winner;

  // at least one master wants this bank
  logic any_valid;

  // payload of the winning master
  tcdm_pkg::bank_req_t win_req;

  assign any_valid = |valid_i;

  // search from the pointer upwards and wrap around
  // the first valid master found is the winner
  always_comb begin : pick_winner
    logic        found;
    int unsigned idx;
    found = 1'b0;
    idx = 0;
    winner = rr_ptr_q;
    for (int unsigned i = 0; i < tcdm_pkg::NUM_MASTERS; i++) begin
      idx = (32'(rr_ptr_q) + i) % tcdm_pkg::NUM_MASTERS;
      if (!found && valid_i[idx]) begin
        found = 1'b1;
        winner = tcdm_pkg::MASTER_IDX_W'(idx);
      end
    end
  end

  // one-hot grant, all zero when nobody requests
  always_comb begin
    for (int unsigned m = 0; m < tcdm_pkg::NUM_MASTERS; m++) begin
      gnt_o[m] = any_valid && (winner == tcdm_pkg::MASTER_IDX_W'(m));
    end
  end

  // the winner's payload goes straight to the bank
  assign win_req = req_i[winner];

  assign bank_req_o = any_valid;
  assign bank_we_o = win_req.we;
  assign bank_addr_o = win_req.addr;
  assign bank_wdata_o = win_req.wdata;
  assign bank_be_o = win_req.be;

  // the pointer moves one past the winner at the grant edge
  // so the winner gets the lowest priority next time
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q <= '0;
    end else if (any_valid) begin
      if (winner == tcdm_pkg::MASTER_IDX_W'(tcdm_pkg::NUM_MASTERS - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= winner + tcdm_pkg::MASTER_IDX_W'(1);
      end
    end
  end

  // rvalid is the grant delayed by one register
  // it marks the cycle in which the bank output holds the winner's read data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= '0;
    end else begin
      rvalid_o <= gnt_o;
    end
  end

endmodule

/* logic/tcdm_port_ctrl.sv */
`timescale 1ns/10ps

// per-master controller for the four-phase req/ack handshake
// it turns one master transfer into one bank access and runs the ack phases
module tcdm_port_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              req_i,
  input  tcdm_pkg::tcdm_req_t               req_data_i,
  output logic                              ack_o,
  output logic [tcdm_pkg::DATA_W-1:0]       rdata_o,
  output logic [tcdm_pkg::NUM_BANKS-1:0]    bank_valid_o,
  output tcdm_pkg::bank_req_t               bank_req_o,
  input  logic [tcdm_pkg::NUM_BANKS-1:0]    gnt_i,
  input  logic [tcdm_pkg::NUM_BANKS-1:0]    rvalid_i,
  input  logic [tcdm_pkg::DATA_W-1:0]       bank_rdata_i [tcdm_pkg::NUM_BANKS]
);

  // idle waits for req, request holds the bank valid until granted,
  // wait_rsp waits for the bank's rvalid, ack holds ack while req is high
  // and release keeps ack low for one cycle before the next transfer
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_RSP,
    ST_ACK,
    ST_RELEASE
  } state_e;

  state_e state_q;
  state_e state_d;

  // request latched when the transfer starts, stable for its whole length
  tcdm_pkg::tcdm_req_t req_q;

  // address split of the latched request
  logic [tcdm_pkg::BANK_SEL_W-1:0]  bank_sel;
  logic [tcdm_pkg::BANK_ADDR_W-1:0] bank_addr;

  // grant and response of our own bank
  logic granted;
  logic responded;

  // read data returned to the master
  logic [tcdm_pkg::DATA_W-1:0] rdata_q;

  assign bank_sel = req_q.addr[tcdm_pkg::BANK_SEL_LSB +: tcdm_pkg::BANK_SEL_W];
  assign bank_addr = req_q.addr[tcdm_pkg::BANK_ADDR_LSB +: tcdm_pkg::BANK_ADDR_W];

  assign granted = gnt_i[bank_sel];
  assign responded = rvalid_i[bank_sel];

  // next state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = ST_REQUEST;
        end
      end
      ST_REQUEST: begin
        // the grant comes in the same cycle when the bank is free
        if (granted) begin
          state_d = ST_WAIT_RSP;
        end
      end
      ST_WAIT_RSP: begin
        if (responded) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: begin
        // a master that keeps req high keeps ack high too
        if (!req_i) begin
          state_d = ST_RELEASE;
        end
      end
      ST_RELEASE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the payload is captured when req is first seen high
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      req_q <= req_data_i;
    end
  end

  // read data is taken from our own bank in the rvalid cycle
  // a write leaves the previous read value in place
  always_ff @(posedge clk_i) begin
    if (state_q == ST_WAIT_RSP && responded && !req_q.we) begin
      rdata_q <= bank_rdata_i[bank_sel];
    end
  end

  // one-hot valid towards the arbiters, only the selected bank is asked
  always_comb begin
    for (int unsigned b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin
      bank_valid_o[b] = (state_q == ST_REQUEST) &&
                        (bank_sel == tcdm_pkg::BANK_SEL_W'(b));
    end
  end

  // bank side payload with the bank-local word index
  always_comb begin
    bank_req_o.we = req_q.we;
    bank_req_o.addr = bank_addr;
    bank_req_o.wdata = req_q.wdata;
    bank_req_o.be = req_q.be;
  end

  assign ack_o = (state_q == ST_ACK);
  assign rdata_o = rdata_q;

endmodule

/* logic/tcdm_cluster_top.sv */
`timescale 1ns/10ps

// TCDM subsystem with four master ports and four word-interleaved banks
// each master has a port controller and each bank has its own arbiter
module tcdm_cluster_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [tcdm_pkg::NUM_MASTERS-1:0]  req_i,
  input  tcdm_pkg::tcdm_req_t               req_data_i [tcdm_pkg::NUM_MASTERS],
  output logic [tcdm_pkg::NUM_MASTERS-1:0]  ack_o,
  output logic [tcdm_pkg::DATA_W-1:0]       rdata_o [tcdm_pkg::NUM_MASTERS]
);

  // controller side vectors, one bit per bank for each master
  logic [tcdm_pkg::NUM_BANKS-1:0] port_valid  [tcdm_pkg::NUM_MASTERS];
  logic [tcdm_pkg::NUM_BANKS-1:0] port_gnt    [tcdm_pkg::NUM_MASTERS];
  logic [tcdm_pkg::NUM_BANKS-1:0] port_rvalid [tcdm_pkg::NUM_MASTERS];

  // every controller's bank payload, seen by all arbiters
  tcdm_pkg::bank_req_t port_req [tcdm_pkg::NUM_MASTERS];

  // arbiter side vectors, one bit per master for each bank
  logic [tcdm_pkg::NUM_MASTERS-1:0] arb_valid  [tcdm_pkg::NUM_BANKS];
  logic [tcdm_pkg::NUM_MASTERS-1:0] arb_gnt    [tcdm_pkg::NUM_BANKS];
  logic [tcdm_pkg::NUM_MASTERS-1:0] arb_rvalid [tcdm_pkg::NUM_BANKS];

  // arbiter to bank signals
  logic                             bank_req   [tcdm_pkg::NUM_BANKS];
  logic                             bank_we    [tcdm_pkg::NUM_BANKS];
  logic [tcdm_pkg::BANK_ADDR_W-1:0] bank_addr  [tcdm_pkg::NUM_BANKS];
  logic [tcdm_pkg::DATA_W-1:0]      bank_wdata [tcdm_pkg::NUM_BANKS];
  logic [tcdm_pkg::BE_W-1:0]        bank_be    [tcdm_pkg::NUM_BANKS];

  // read data of every bank, each controller picks its own
  logic [tcdm_pkg::DATA_W-1:0] bank_rdata [tcdm_pkg::NUM_BANKS];

  // the interconnect is only a transpose between master and bank views
  for (genvar m = 0; m < tcdm_pkg::NUM_MASTERS; m++) begin : g_xpose_m
    for (genvar b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin : g_xpose_b
      assign arb_valid[b][m] = port_valid[m][b];
      assign port_gnt[m][b] = arb_gnt[b][m];
      assign port_rvalid[m][b] = arb_rvalid[b][m];
    end
  end

  // one handshake controller per master port
  for (genvar m = 0; m < tcdm_pkg::NUM_MASTERS; m++) begin : g_port
    tcdm_port_ctrl i_port_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i[m]),
      .req_data_i   (req_data_i[m]),
      .ack_o        (ack_o[m]),
      .rdata_o      (rdata_o[m]),
      .bank_valid_o (port_valid[m]),
      .bank_req_o   (port_req[m]),
      .gnt_i        (port_gnt[m]),
      .rvalid_i     (port_rvalid[m]),
      .bank_rdata_i (bank_rdata)
    );
  end

  // one arbiter and one SRAM bank per bank slot
  for (genvar b = 0; b < tcdm_pkg::NUM_BANKS; b++) begin : g_bank
    tcdm_bank_arbiter i_arbiter (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .valid_i      (arb_valid[b]),
      .req_i        (port_req),
      .gnt_o        (arb_gnt[b]),
      .rvalid_o     (arb_rvalid[b]),
      .bank_req_o   (bank_req[b]),
      .bank_we_o    (bank_we[b]),
      .bank_addr_o  (bank_addr[b]),
      .bank_wdata_o (bank_wdata[b]),
      .bank_be_o    (bank_be[b])
    );

    tcdm_bank i_bank (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

/* verif/tcdm_tb.sv */
`timescale 1ns/10ps

// directed testbench for the TCDM subsystem
// every master port is driven through complete four-phase transfers and each
// read is compared with a reference memory that follows the byte lane rule
module tcdm_tb;

  // number of cycles a single wait may take before the master counts as hung
  localparam int TIMEOUT_CYCLES = 64;

  logic                             clk;
  logic                             rst;
  logic [tcdm_pkg::NUM_MASTERS-1:0] req;
  tcdm_pkg::tcdm_req_t              req_data [tcdm_pkg::NUM_MASTERS];
  logic [tcdm_pkg::NUM_MASTERS-1:0] ack;
  logic [tcdm_pkg::DATA_W-1:0]      rdata [tcdm_pkg::NUM_MASTERS];

  // reference memory indexed by the global word address
  logic [tcdm_pkg::DATA_W-1:0] ref_mem [2**tcdm_pkg::ADDR_W];

  int checks;
  int mismatches;
  int timeouts;

  tcdm_cluster_top DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .rdata_o    (rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // word interleaving puts word idx of bank b at global address idx*banks+b
  function automatic logic [tcdm_pkg::ADDR_W-1:0] make_addr(input int bank, input int idx);
    return tcdm_pkg::ADDR_W'(idx * tcdm_pkg::NUM_BANKS + bank);
  endfunction

  // only lanes with their byte enable set take the new byte
  task automatic ref_write(input logic [tcdm_pkg::ADDR_W-1:0] addr,
                           input logic [tcdm_pkg::DATA_W-1:0] wdata,
                           input logic [tcdm_pkg::BE_W-1:0] be);
    for (int lane = 0; lane < tcdm_pkg::BE_W; lane++) begin
      if (be[lane]) begin
        ref_mem[addr][lane*8 +: 8] = wdata[lane*8 +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      mismatches++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // polls ack of one master on falling edges until it reaches the level
  task automatic wait_ack(input int m, input logic level, input string phase);
    int cycles;
    cycles = 0;
    while (ack[m] !== level) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("timeout: master %0d hung while %s", m, phase);
        timeouts++;
        break;
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // one complete four-phase transfer, rd is sampled while ack is high
  task automatic transfer(input int m, input logic we,
                          input logic [tcdm_pkg::ADDR_W-1:0] addr,
                          input logic [tcdm_pkg::DATA_W-1:0] wdata,
                          input logic [tcdm_pkg::BE_W-1:0] be,
                          output logic [tcdm_pkg::DATA_W-1:0] rd);
    tcdm_pkg::tcdm_req_t r;
    r.we = we;
    r.addr = addr;
    r.wdata = wdata;
    r.be = be;
    @(negedge clk);
    req_data[m] = r;
    req[m] = 1'b1;
    wait_ack(m, 1'b1, "waiting for ack to rise");
    rd = rdata[m];
    @(negedge clk);
    req[m] = 1'b0;
    wait_ack(m, 1'b0, "waiting for ack to fall");
  endtask

  // the reference is updated once the write has been acknowledged
  task automatic write_word(input int m, input logic [tcdm_pkg::ADDR_W-1:0] addr,
                            input logic [tcdm_pkg::DATA_W-1:0] wdata,
                            input logic [tcdm_pkg::BE_W-1:0] be);
    logic [tcdm_pkg::DATA_W-1:0] unused;
    transfer(m, 1'b1, addr, wdata, be, unused);
    ref_write(addr, wdata, be);
  endtask

  task automatic read_check(input string name, input int m,
                            input logic [tcdm_pkg::ADDR_W-1:0] addr);
    logic [tcdm_pkg::DATA_W-1:0] rd;
    transfer(m, 1'b0, addr, '0, '0, rd);
    check_value(name, ref_mem[addr], rd);
  endtask

  task automatic test_after_reset();
    logic [tcdm_pkg::ADDR_W-1:0] addr;
    addr = tcdm_pkg::ADDR_W'($urandom());
    check_value("reset_ack", 32'd0, {28'd0, ack});
    write_word(0, addr, $urandom(), 4'hf);
    read_check("reset_write_read", 0, addr);
  endtask

  // a full word first, then two partial writes merged into it
  task automatic test_byte_enables();
    logic [tcdm_pkg::ADDR_W-1:0] addr;
    addr = make_addr(1, 8'h05);
    write_word(1, addr, 32'ha1b2_c3d4, 4'hf);
    read_check("be_full", 1, addr);
    write_word(1, addr, $urandom(), 4'b0101);
    read_check("be_lanes_0_2", 1, addr);
    write_word(1, addr, $urandom(), 4'b1000);
    read_check("be_lane_3", 1, addr);
  endtask

  // eight consecutive addresses cover every bank twice
  task automatic test_interleave();
    for (int i = 0; i < 8; i++) begin
      write_word(2, tcdm_pkg::ADDR_W'(10'h140 + i), $urandom(), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      read_check("interleave", 2, tcdm_pkg::ADDR_W'(10'h140 + i));
    end
  endtask

  // all masters hit bank 2 at once, first with writes then with reads
  task automatic test_contention();
    logic [tcdm_pkg::DATA_W-1:0] d [4];
    for (int m = 0; m < 4; m++) begin
      d[m] = $urandom();
    end
    fork
      write_word(0, make_addr(2, 8'h30), d[0], 4'hf);
      write_word(1, make_addr(2, 8'h31), d[1], 4'hf);
      write_word(2, make_addr(2, 8'h32), d[2], 4'hf);
      write_word(3, make_addr(2, 8'h33), d[3], 4'hf);
    join
    // each master reads a word written by another master
    fork
      read_check("contention", 0, make_addr(2, 8'h33));
      read_check("contention", 1, make_addr(2, 8'h30));
      read_check("contention", 2, make_addr(2, 8'h31));
      read_check("contention", 3, make_addr(2, 8'h32));
    join
  endtask

  // four reads in flight together, each master on a different bank
  task automatic test_parallel_banks();
    for (int b = 0; b < 4; b++) begin
      write_word(0, make_addr(b, 8'h90), $urandom(), 4'hf);
    end
    fork
      read_check("parallel_bank1", 0, make_addr(1, 8'h90));
      read_check("parallel_bank2", 1, make_addr(2, 8'h90));
      read_check("parallel_bank3", 2, make_addr(3, 8'h90));
      read_check("parallel_bank0", 3, make_addr(0, 8'h90));
    join
  endtask

  // master 3 keeps req high after ack and the response must hold still
  task automatic test_back_pressure();
    tcdm_pkg::tcdm_req_t r;
    logic [tcdm_pkg::ADDR_W-1:0] addr;
    logic [tcdm_pkg::DATA_W-1:0] held;
    addr = make_addr(3, 8'h20);
    write_word(2, addr, $urandom(), 4'hf);
    r.we = 1'b0;
    r.addr = addr;
    r.wdata = '0;
    r.be = '0;
    @(negedge clk);
    req_data[3] = r;
    req[3] = 1'b1;
    wait_ack(3, 1'b1, "waiting for ack to rise under back-pressure");
    held = rdata[3];
    check_value("back_pressure_data", ref_mem[addr], held);
    repeat (6) begin
      @(negedge clk);
      check_value("back_pressure_ack", 32'd1, {31'd0, ack[3]});
      check_value("back_pressure_hold", held, rdata[3]);
    end
    req[3] = 1'b0;
    wait_ack(3, 1'b0, "waiting for ack to fall after back-pressure");
  endtask

  initial begin
    void'($urandom(32'h56e2_f2b3));
    checks = 0;
    mismatches = 0;
    timeouts = 0;
    rst = 1'b1;
    req = '0;
    for (int m = 0; m < tcdm_pkg::NUM_MASTERS; m++) begin
      req_data[m] = '0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;

    test_after_reset();
    test_byte_enables();
    test_interleave();
    test_contention();
    test_parallel_banks();
    test_back_pressure();

    $display("tcdm_tb: %0d checks, %0d mismatches, %0d timeouts",
             checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/tcdm_pkg.sv
logic/tcdm_bank.sv
logic/tcdm_bank_arbiter.sv
logic/tcdm_port_ctrl.sv
logic/tcdm_cluster_top.sv
verif/tcdm_tb.sv
